//--- common/mult_defs.svh
/* global sizes for the multiply unit, change here and rebuild everything
   MULT_STAGES must divide 2*MULT_XLEN or the pipe refuses to elaborate */
`ifndef MULT_DEFS_SVH
`define MULT_DEFS_SVH

////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////

`define MULT_XLEN 32 // operand and result width
`define MULT_DLEN (2*`MULT_XLEN) // extended operand and full product

// default latency in cycles, one slice of the multiplier per stage
`define MULT_STAGES 4

////////////////////////////////////////////////////////////
// fields carried beside the operation
////////////////////////////////////////////////////////////

`define MULT_ROB_BITS 6 // reorder buffer entry index
`define MULT_REG_BITS 5 // architectural destination register

`endif

//--- common/mult_pkg.sv
/* types shared by the multiply unit, sizes from mult_defs.svh
   func encoding follows funct3 of the M extension for MUL..MULHU */
`include "mult_defs.svh"

package mult_pkg;

	////////////////////////////////////////////////////////////
	// data words
	////////////////////////////////////////////////////////////

	typedef logic [`MULT_XLEN-1:0] word_t;  // rs1, rs2, rd value
	typedef logic [`MULT_DLEN-1:0] dword_t; // extended operand / product

	////////////////////////////////////////////////////////////
	// operation and bookkeeping
	////////////////////////////////////////////////////////////

	typedef logic [`MULT_ROB_BITS-1:0] rob_tag_t;
	typedef logic [`MULT_REG_BITS-1:0] reg_idx_t;

	// low two bits of funct3, OP opcode with funct7 = 0000001
	typedef enum logic [1:0] {
		MUL    = 2'b00, // low word, sign does not matter
		MULH   = 2'b01, // high word, signed x signed
		MULHSU = 2'b10, // high word, signed x unsigned
		MULHU  = 2'b11  // high word, unsigned x unsigned
	} mult_func_t;

	// returned untouched next to the result
	typedef struct packed {
		rob_tag_t rob_tag;  // where the result retires
		reg_idx_t dest_reg; // where the result is written
	} mult_tag_t;

	// every op except MUL wants the upper half of the product
	function automatic logic mult_high_word(input mult_func_t f);
		logic high;
		high = (f != MUL);
		return high;
	endfunction

endpackage

//--- common/mult_stage_if.sv
/* one hop between multiply stages, every signal driven by the sender
   no handshake, the data fields mean something only while valid is high */
`timescale 1ns/1ps

interface mult_stage_if;
	import mult_pkg::*;

	logic   valid;   // one-cycle strobe per operation
	dword_t mcand;   // multiplicand, shifted left past the slices used so far
	dword_t mplier;  // multiplier, shifted right likewise
	dword_t product; // running sum of partial products

	// sending stage
	modport up (
		output valid,
		output mcand,
		output mplier,
		output product
	);

	// receiving stage
	modport down (
		input valid,
		input mcand,
		input mplier,
		input product
	);

endinterface

//--- multiplier/mult_stage.sv
/* adds one multiplier slice of partial products per cycle
   slice is MULT_DLEN / NUM_STAGES bits, only valid is reset */
`timescale 1ns/1ps
`include "mult_defs.svh"

module mult_stage #(
	parameter int NUM_STAGES = `MULT_STAGES
) (
	input logic        clock,
	input logic        reset,
	mult_stage_if.down prev,
	mult_stage_if.up   next
);
	import mult_pkg::*;

	localparam int SLICE = `MULT_DLEN / NUM_STAGES; // multiplier bits eaten here

	dword_t part_d;     // slice times multiplicand
	dword_t part_q;
	dword_t sum_q;      // incoming running sum
	logic   seen_valid; // an op has entered since reset

	////////////////////////////////////////////////////////////
	// datapath, free running
	////////////////////////////////////////////////////////////

	// zero extended slice, upper product bits fall off like mod 2^DLEN
	assign part_d = dword_t'(prev.mplier[SLICE-1:0]) * prev.mcand;

	always_ff @(posedge clock) begin
		sum_q       <= prev.product;
		part_q      <= part_d;
		next.mcand  <= prev.mcand << SLICE;  // line up with next slice
		next.mplier <= prev.mplier >> SLICE; // drop consumed bits
	end

	// add after the register, keeps the multiply and the add in separate cycles
	assign next.product = sum_q + part_q;

	////////////////////////////////////////////////////////////
	// control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			next.valid <= 1'b0; // drops anything in flight
		end else begin
			next.valid <= prev.valid;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			seen_valid <= 1'b0;
		end else if (prev.valid) begin
			seen_valid <= 1'b1;
		end
	end

	// nothing leaves this stage after reset unless something entered
	a_no_spurious_valid: assert property (
		@(posedge clock) disable iff (reset)
		next.valid |-> seen_valid
	) else $error("stage output valid without any input valid since reset");

endmodule

//--- multiplier/mult_pipe.sv
/* fully pipelined multiply, one op per cycle, done exactly NUM_STAGES later
   NUM_STAGES must divide MULT_DLEN, product is the full double-width result */
`timescale 1ns/1ps
`include "mult_defs.svh"

module mult_pipe #(
	parameter int NUM_STAGES = `MULT_STAGES
) (
	input  logic             clock,
	input  logic             reset,
	input  logic             start,
	input  logic             mcand_signed,  // treat mcand as two's complement
	input  logic             mplier_signed, // treat mplier as two's complement
	input  mult_pkg::word_t  mcand,
	input  mult_pkg::word_t  mplier,
	output mult_pkg::dword_t product,
	output logic             done
);
	import mult_pkg::*;

	dword_t mcand_ext;
	dword_t mplier_ext;

	// hop[0] feeds the first stage, hop[NUM_STAGES] is the pipe output
	mult_stage_if hop [NUM_STAGES+1] ();

	if (`MULT_DLEN % NUM_STAGES != 0) begin : g_bad_depth
		$error("NUM_STAGES must divide the double-width operand size");
	end

	////////////////////////////////////////////////////////////
	// operand extension
	////////////////////////////////////////////////////////////

	// upper half is the sign bit when signed, zero otherwise
	assign mcand_ext  = {{`MULT_XLEN{mcand_signed & mcand[`MULT_XLEN-1]}}, mcand};
	assign mplier_ext = {{`MULT_XLEN{mplier_signed & mplier[`MULT_XLEN-1]}}, mplier};

	// seed the chain
	assign hop[0].valid   = start;
	assign hop[0].mcand   = mcand_ext;
	assign hop[0].mplier  = mplier_ext;
	assign hop[0].product = '0; // nothing summed yet

	////////////////////////////////////////////////////////////
	// stage chain
	////////////////////////////////////////////////////////////

	for (genvar g = 0; g < NUM_STAGES; g++) begin : g_stage
		mult_stage #(
			.NUM_STAGES (NUM_STAGES)
		) i_mult_stage (
			.clock (clock),
			.reset (reset),
			.prev  (hop[g]),
			.next  (hop[g+1])
		);
	end

	// last hop's shifted operands are spent, only sum and strobe leave
	assign product = hop[NUM_STAGES].product;
	assign done    = hop[NUM_STAGES].valid;

	////////////////////////////////////////////////////////////
	// latency checks
	////////////////////////////////////////////////////////////

	// every start comes out, NUM_STAGES cycles on
	a_start_to_done: assert property (
		@(posedge clock) disable iff (reset)
		start |-> ##NUM_STAGES done
	) else $error("start without done %0d cycles later", NUM_STAGES);

	// and nothing comes out that did not go in
	a_done_from_start: assert property (
		@(posedge clock) disable iff (reset)
		done |-> $past(start, NUM_STAGES)
	) else $error("done without a start %0d cycles earlier", NUM_STAGES);

endmodule

//--- source/tag_delay.sv
/* fixed latency side line for anything that rides along with an op
   DEPTH is at least 1, slots not loaded hold all zero */
`timescale 1ns/1ps
`include "mult_defs.svh"

module tag_delay #(
	parameter int  DEPTH     = `MULT_STAGES, // match the pipe latency
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     reset,
	input  logic     load, // din is meaningful this cycle
	input  payload_t din,
	output payload_t dout
);

	localparam payload_t EMPTY = payload_t'('0); // idle slot

	payload_t line_q [DEPTH]; // line_q[0] is the newest entry
	payload_t head_d;

	if (DEPTH < 1) begin : g_bad_depth
		$error("tag_delay needs DEPTH of at least 1");
	end

	// bubble in when nothing starts, so stale values never ride along
	assign head_d = load ? din : EMPTY;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				line_q[i] <= EMPTY; // flush everything in flight
			end
		end else begin
			line_q[0] <= head_d;
			for (int i = 1; i < DEPTH; i++) begin
				line_q[i] <= line_q[i-1]; // shift every cycle, no stall
			end
		end
	end

	assign dout = line_q[DEPTH-1];

endmodule

//--- source/mult_fu.sv
/* M-extension multiply unit, new op any cycle, result MULT_STAGES cycles later
   no back-pressure, the consumer must take result and tag_out while done is high */
`timescale 1ns/1ps
`include "mult_defs.svh"

module mult_fu (
	input  logic                clock,
	input  logic                reset,
	input  logic                start,   // one-cycle strobe per op
	input  mult_pkg::mult_func_t func,
	input  mult_pkg::word_t     opa,     // rs1, multiplicand
	input  mult_pkg::word_t     opb,     // rs2, multiplier
	input  mult_pkg::mult_tag_t tag_in,
	output mult_pkg::word_t     result,
	output logic                done,
	output mult_pkg::mult_tag_t tag_out
);
	import mult_pkg::*;

	localparam int DEPTH = `MULT_STAGES; // same for pipe and side lines

	logic       opa_signed;
	logic       opb_signed;
	dword_t     product;  // full product at pipe output
	mult_func_t func_q;   // func of the op now leaving the pipe

	////////////////////////////////////////////////////////////
	// function decode
	////////////////////////////////////////////////////////////

	always_comb begin
		case (func)
			MUL, MULH: begin
				opa_signed = 1'b1; // low word of MUL is sign agnostic anyway
				opb_signed = 1'b1;
			end
			MULHSU: begin
				opa_signed = 1'b1;
				opb_signed = 1'b0;
			end
			default: begin // MULHU
				opa_signed = 1'b0;
				opb_signed = 1'b0;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// datapath and side lines
	////////////////////////////////////////////////////////////

	mult_pipe #(
		.NUM_STAGES (DEPTH)
	) i_mult_pipe (
		.clock         (clock),
		.reset         (reset),
		.start         (start),
		.mcand_signed  (opa_signed),
		.mplier_signed (opb_signed),
		.mcand         (opa),
		.mplier        (opb),
		.product       (product),
		.done          (done)
	);

	// func follows the data so the word select at the end matches its op
	tag_delay #(
		.DEPTH     (DEPTH),
		.payload_t (mult_func_t)
	) i_func_delay (
		.clock (clock),
		.reset (reset),
		.load  (start),
		.din   (func),
		.dout  (func_q)
	);

	// rob tag and rd come back in the same cycle as their result
	tag_delay #(
		.DEPTH     (DEPTH),
		.payload_t (mult_tag_t)
	) i_tag_delay (
		.clock (clock),
		.reset (reset),
		.load  (start),
		.din   (tag_in),
		.dout  (tag_out)
	);

	////////////////////////////////////////////////////////////
	// result select
	////////////////////////////////////////////////////////////

	// upper half for MULH, MULHSU, MULHU
	assign result = mult_high_word(func_q) ? product[`MULT_DLEN-1:`MULT_XLEN]
	                                       : product[`MULT_XLEN-1:0];

	// an X func would pick random signedness and a random word 4 cycles on
	a_func_known: assert property (
		@(posedge clock) disable iff (reset)
		start |-> !$isunknown(func)
	) else $error("func unknown while start is high");

endmodule

//--- verif/mult_fu_tb.sv
/* random and corner multiplies against a longhand model, seed 19
   assumes a 32-bit word for the random operand builder */
`timescale 1ns/1ps
`include "mult_defs.svh"

module mult_fu_tb;
	import mult_pkg::*;

	localparam int STAGES        = `MULT_STAGES;
	localparam int CLOCK_PERIOD  = 8;
	localparam int RESET_CYCLES  = 5;
	localparam int DRAIN_CYCLES  = STAGES + 4;   // longest wait for the queue to empty
	localparam int N_MUL         = 50;
	localparam int N_RANDOM_HIGH = 20;           // random ops after the corner grid
	localparam int N_CORNER      = 5;
	localparam int N_B2B         = 200;
	localparam int N_GAPS        = 100;
	localparam int N_PRE_RESET   = 6;
	localparam int N_POST_RESET  = 20;
	localparam int TOTAL_OPS = N_MUL + 3 * (N_CORNER * N_CORNER + N_RANDOM_HIGH)
		+ N_B2B + N_GAPS + N_PRE_RESET + N_POST_RESET;
	localparam longint WATCHDOG_NS =
		longint'(TOTAL_OPS) * (STAGES + 4) * CLOCK_PERIOD + 1000 * CLOCK_PERIOD;

	localparam word_t CORNERS [N_CORNER] = '{
		32'h8000_0000, // most negative
		32'hffff_ffff, // minus one
		32'h0000_0000,
		32'h0000_0001,
		32'h7fff_ffff  // most positive
	};

	// one outstanding op in the model
	typedef struct packed {
		word_t       result;
		mult_tag_t   tag;
		logic [31:0] due; // cycle in which done must be high
	} exp_op_t;

	logic       clock = 1'b0;
	logic       reset;
	logic       start;
	mult_func_t func;
	word_t      opa;
	word_t      opb;
	mult_tag_t  tag_in;
	word_t      result;
	logic       done;
	mult_tag_t  tag_out;

	exp_op_t     pending [$];
	exp_op_t     head;
	logic        expect_done;
	logic [31:0] cycle = 0;
	logic [31:0] lcg_state = 32'd19;
	int          checks = 0;
	int          errors = 0;
	int          test_errors;
	int          test_ops;
	int          tests = 0;

	mult_fu i_mult_fu (
		.clock   (clock),
		.reset   (reset),
		.start   (start),
		.func    (func),
		.opa     (opa),
		.opb     (opb),
		.tag_in  (tag_in),
		.result  (result),
		.done    (done),
		.tag_out (tag_out)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	always @(posedge clock) cycle <= cycle + 1; // edge count, read mid-cycle only

	////////////////////////////////////////////////////////////
	// random numbers and reference model
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// upper halves only, the low LCG bits cycle too fast
	function automatic word_t rand_word();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = lcg_next();
		lo = lcg_next();
		return {hi[31:16], lo[31:16]};
	endfunction

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = lcg_next();
		return int'(r[31:16]) % n;
	endfunction

	// extend each operand by its own signedness, then pick the word
	function automatic word_t expected_result(input mult_func_t f, input word_t a, input word_t b);
		logic signed [`MULT_DLEN-1:0] ea;
		logic signed [`MULT_DLEN-1:0] eb;
		logic signed [`MULT_DLEN-1:0] prod;
		if (f == MULHU) begin
			ea = a;          // opa unsigned only in MULHU
		end else begin
			ea = $signed(a);
		end
		if (f == MULH || f == MUL) begin
			eb = $signed(b); // opb signed in MUL, MULH
		end else begin
			eb = b;
		end
		prod = ea * eb;
		if (f == MUL) begin
			return prod[`MULT_XLEN-1:0];
		end
		return prod[`MULT_DLEN-1:`MULT_XLEN];
	endfunction

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_word(input string name, input word_t exp, input word_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			test_errors++;
			$display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_tag(input string name, input mult_tag_t exp, input mult_tag_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			test_errors++;
			$display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_done(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			test_errors++;
			$display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	// mid-cycle sample, outputs settled since the rising edge
	always @(negedge clock) begin
		if (!reset) begin
			expect_done = (pending.size() > 0) && (pending[0].due == cycle);
			if (done === 1'b1 && pending.size() == 0) begin
				errors++;
				test_errors++;
				$display("error at %0t ns: done is high with no operation outstanding", $time);
			end else if (expect_done && done !== 1'b1) begin
				errors++;
				test_errors++;
				$display("error at %0t ns: no done for the op due in cycle %0d",
					$time, pending[0].due);
				void'(pending.pop_front());
			end else begin
				check_done("done", expect_done, done);
				if (expect_done) begin
					head = pending.pop_front();
					check_word("result", head.result, result);
					check_tag("tag_out", head.tag, tag_out);
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus tasks, all called 1 ns after a rising edge
	////////////////////////////////////////////////////////////

	task automatic issue_op(input mult_func_t f, input word_t a, input word_t b);
		logic [31:0] r;
		mult_tag_t   t;
		exp_op_t     e;
		r = lcg_next();
		t = r[31-:$bits(mult_tag_t)];
		start  = 1'b1;
		func   = f;
		opa    = a;
		opb    = b;
		tag_in = t;
		// start high this cycle, done high STAGES cycles on
		e.result = expected_result(f, a, b);
		e.tag    = t;
		e.due    = cycle + STAGES;
		pending.push_back(e);
		test_ops++;
		@(posedge clock);
		#1;
		start = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clock);
			#1;
		end
	endtask

	function automatic mult_func_t rand_func();
		logic [31:0] r;
		r = lcg_next();
		return mult_func_t'(r[17:16]);
	endfunction

	task automatic begin_test();
		test_errors = 0;
		test_ops    = 0;
	endtask

	task automatic end_test(input string name);
		int waited;
		waited = 0;
		while (pending.size() != 0 && waited < DRAIN_CYCLES) begin
			@(posedge clock);
			waited++;
		end
		#1;
		if (pending.size() != 0) begin
			errors++;
			test_errors++;
			$display("error at %0t ns: %0d results still missing after %0d idle cycles",
				$time, pending.size(), DRAIN_CYCLES);
			pending.delete();
		end
		tests++;
		$display("test %-16s %4d ops, %0d errors", name, test_ops, test_errors);
	endtask

	// full grid of corner pairs, then random operands
	task automatic corner_and_random(input mult_func_t f);
		for (int i = 0; i < N_CORNER; i++) begin
			for (int j = 0; j < N_CORNER; j++) begin
				issue_op(f, CORNERS[i], CORNERS[j]);
			end
		end
		repeat (N_RANDOM_HIGH) begin
			issue_op(f, rand_word(), rand_word());
			idle_cycles(rand_below(3));
		end
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		reset  = 1'b1;
		start  = 1'b0;
		func   = MUL;
		opa    = '0;
		opb    = '0;
		tag_in = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		reset = 1'b0;

		begin_test();
		repeat (N_MUL) begin
			issue_op(MUL, rand_word(), rand_word());
			idle_cycles(rand_below(3));
		end
		end_test("mul_random");

		begin_test();
		corner_and_random(MULH);
		end_test("mulh_corners");

		begin_test();
		corner_and_random(MULHSU);
		corner_and_random(MULHU);
		end_test("mulhsu_mulhu");

		begin_test();
		repeat (N_B2B) issue_op(rand_func(), rand_word(), rand_word()); // start every cycle
		end_test("back_to_back");

		begin_test();
		repeat (N_GAPS) begin
			issue_op(rand_func(), rand_word(), rand_word());
			idle_cycles(rand_below(8));
		end
		end_test("random_gaps");

		begin_test();
		repeat (N_PRE_RESET) issue_op(rand_func(), rand_word(), rand_word());
		reset = 1'b1; // later ops still in the pipe
		pending.delete();
		idle_cycles(3);
		reset = 1'b0;
		idle_cycles(STAGES + 2); // monitor expects done low throughout
		repeat (N_POST_RESET) issue_op(rand_func(), rand_word(), rand_word());
		end_test("reset_in_flight");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// bound on the whole run, scaled by the op count
	initial begin
		#(WATCHDOG_NS);
		$display("error: watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
		$display("Regression failed");
		$finish;
	end

endmodule

//--- compile.f
+incdir+common
common/mult_pkg.sv
common/mult_stage_if.sv
multiplier/mult_stage.sv
multiplier/mult_pipe.sv
source/tag_delay.sv
source/mult_fu.sv
verif/mult_fu_tb.sv

//--- Makefile
# Verilator build and run for the multiply unit testbench
# every variable below can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= mult_fu_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_LINE ?= Regression passed

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	$(SIM) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_LINE)" $(LOG); then \
		echo "simulation result: pass"; \
	else \
		echo "simulation result: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
